// ==== Bender.yml ====
package:
  name: sd_card_emu

sources:
  - files:
      - hdl/sdBusPkg.sv
      - hdl/sdCmdPkg.sv
      - hdl/sdLinkIfs.sv
      - hdl/sdCrc7.sv
      - hdl/sdCmdReceiver.sv
      - hdl/sdCardControl.sv
      - hdl/sdRespTransmitter.sv
      - hdl/sdReadDataSender.sv
      - hdl/sdCardTop.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/sdCardTb.sv

// ==== hdl/sdBusPkg.sv ====
`default_nettype none

// ===================================================================
// SD bus framing, shared by the command and data line blocks
// ===================================================================
package sdBusPkg;

    // Command and response frame, start bit through end bit
    localparam int FrameBits = 48;

    // Start, transmission, index and argument bits
    localparam int HdrBits = 40;

    localparam int Crc7Bits = 7;
    localparam int Crc16Bits = 16;

    // 4-bit bus mode
    localparam int DatLines = 4;

    localparam logic StartBit = 1'b0;
    localparam logic EndBit = 1'b1;

    // Transmission bit: 1 from the host, 0 from the card
    localparam logic HostTxBit = 1'b1;
    localparam logic CardTxBit = 1'b0;

endpackage

`default_nettype wire

// ==== hdl/sdCardControl.sv ====
`default_nettype none

module sdCardControl import sdCmdPkg::*; #(
    parameter logic [15:0] CardRca = 16'hAAAA
) (
    input  logic clk,
    input  logic rst_,
    sdCmdIf.ctl  cmd,
    sdRespIf.ctl resp,
    output logic readStart,
    output logic readStop,
    input  logic readActive
);

    cardStateT   state;
    cardStateT   nextState;
    logic        appFlag;
    logic        pendStart;
    logic        busyQ;
    logic [31:0] status;
    logic        respond;
    cmdIndexT    rIdx;
    logic [31:0] rArg;
    logic        rNoCrc;
    logic        startReq;
    logic        stopReq;

    // ===================================================================
    // Command decode
    // ===================================================================
    always_comb begin
        // Status reports the state before this command
        status = '0;
        status[StatusStateLsb +: 4] = state;
        status[StatusReadyBit] = 1'b1;
        status[StatusAppBit] = (cmd.index == CmdAppCmd);

        respond = 1'b0;
        nextState = state;
        rIdx = cmd.index;
        rArg = status;
        rNoCrc = 1'b0;
        startReq = 1'b0;
        stopReq = 1'b0;

        if (appFlag && cmd.index == AcmdOpCond) begin
            respond = 1'b1;
            rIdx = RespR3Index;
            rArg = OcrReady;
            rNoCrc = 1'b1;
            nextState = Ready;
        end else begin
            case (cmd.index)
                CmdGoIdle: begin
                    nextState = Idle;
                    stopReq = (state == Data);
                end
                CmdSendRca: begin
                    respond = 1'b1;
                    rArg = {CardRca, status[15:0]};
                    nextState = Stby;
                end
                CmdSelect: begin
                    // Another card's address leaves this one untouched
                    if (cmd.arg.rcaArg.rca == CardRca) begin
                        respond = 1'b1;
                        nextState = Tran;
                    end
                end
                CmdIfCond: begin
                    respond = 1'b1;
                    rArg = {20'b0, cmd.arg.raw[11:0]};
                end
                CmdStop: begin
                    if (state == Data) begin
                        respond = 1'b1;
                        nextState = Tran;
                        stopReq = 1'b1;
                    end
                end
                CmdReadMulti: begin
                    // Wait until a stopped stream has sent its last block
                    if (state == Tran && !readActive) begin
                        respond = 1'b1;
                        nextState = Data;
                        startReq = 1'b1;
                    end
                end
                CmdAppCmd: begin
                    respond = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // Data starts once the response has left the line
    assign readStart = pendStart && busyQ && !resp.busy;

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state <= Idle;
            appFlag <= 1'b0;
            pendStart <= 1'b0;
            busyQ <= 1'b0;
            readStop <= 1'b0;
            resp.valid <= 1'b0;
        end else begin
            busyQ <= resp.busy;
            readStop <= 1'b0;
            resp.valid <= 1'b0;
            if (readStart) begin
                pendStart <= 1'b0;
            end
            // Commands seen while a response is still going out are ignored
            if (cmd.valid && !resp.busy) begin
                state <= nextState;
                appFlag <= (cmd.index == CmdAppCmd);
                resp.valid <= respond;
                readStop <= stopReq;
                if (startReq) begin
                    pendStart <= 1'b1;
                end else if (stopReq) begin
                    pendStart <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.valid && !resp.busy) begin
            resp.index <= rIdx;
            resp.arg <= rArg;
            resp.noCrc <= rNoCrc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdCardTop.sv ====
`default_nettype none

module sdCardTop import sdBusPkg::*; #(
    parameter logic [15:0] CardRca = 16'hAAAA,
    parameter int RespGap = 2,
    parameter int DataGap = 8,
    parameter int BlockBytes = 512
) (
    input  logic                clk,
    input  logic                rst_,
    // Host command line, idles high
    input  logic                cmdIn,
    output logic                cmdOut,
    output logic                cmdOe,
    output logic [DatLines-1:0] datOut,
    output logic                datOe
);

    logic readStart;
    logic readStop;
    logic readActive;

    sdCmdIf cmdLink ();
    sdRespIf respLink ();

    sdCmdReceiver cmdRx (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .cmd    (cmdLink.rx)
    );

    sdCardControl #(
        .CardRca (CardRca)
    ) cardCtl (
        .clk        (clk),
        .rst_       (rst_),
        .cmd        (cmdLink.ctl),
        .resp       (respLink.ctl),
        .readStart  (readStart),
        .readStop   (readStop),
        .readActive (readActive)
    );

    sdRespTransmitter #(
        .RespGap (RespGap)
    ) respTx (
        .clk    (clk),
        .rst_   (rst_),
        .resp   (respLink.tx),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe)
    );

    sdReadDataSender #(
        .BlockBytes (BlockBytes),
        .DataGap    (DataGap)
    ) datTx (
        .clk        (clk),
        .rst_       (rst_),
        .readStart  (readStart),
        .readStop   (readStop),
        .readActive (readActive),
        .datOut     (datOut),
        .datOe      (datOe)
    );

endmodule

`default_nettype wire

// ==== hdl/sdCmdPkg.sv ====
`default_nettype none

// ===================================================================
// Card command set and status layout
// ===================================================================
package sdCmdPkg;

    typedef logic [5:0] cmdIndexT;

    localparam cmdIndexT CmdGoIdle = 6'd0;
    localparam cmdIndexT CmdSendRca = 6'd3;
    localparam cmdIndexT CmdSelect = 6'd7;
    localparam cmdIndexT CmdIfCond = 6'd8;
    localparam cmdIndexT CmdStop = 6'd12;
    localparam cmdIndexT CmdReadMulti = 6'd18;
    localparam cmdIndexT CmdAppCmd = 6'd55;
    localparam cmdIndexT AcmdOpCond = 6'd41;

    // R3 carries a reserved index field of all ones
    localparam cmdIndexT RespR3Index = 6'h3F;

    typedef enum logic [3:0] {
        Idle  = 4'd0,
        Ready = 4'd1,
        Stby  = 4'd3,
        Tran  = 4'd4,
        Data  = 4'd5
    } cardStateT;

    // Card status word
    localparam int StatusStateLsb = 9;
    localparam int StatusReadyBit = 8;
    localparam int StatusAppBit = 5;

    // Power-up done, full 2.7-3.6 V window
    localparam logic [31:0] OcrReady = 32'h80FF_8000;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] rca;
            logic [15:0] stuff;
        } rcaArg;
    } sdArgU;

endpackage

`default_nettype wire

// ==== hdl/sdCmdReceiver.sv ====
`default_nettype none

module sdCmdReceiver import sdBusPkg::*; (
    input  logic clk,
    input  logic rst_,
    input  logic cmdIn,
    sdCmdIf.rx   cmd
);

    localparam int CntW = $clog2(FrameBits);
    // Field positions in the 47 bits before the end bit
    localparam int ArgLsb = Crc7Bits;
    localparam int IdxLsb = ArgLsb + 32;
    localparam int TxBitPos = IdxLsb + 6;

    logic                active;
    logic [CntW-1:0]     cnt;
    logic [FrameBits-2:0] sr;
    logic [Crc7Bits-1:0] crc;
    logic                crcEn;
    logic                lastBit;
    logic                frameOk;

    // Start bit arrives while idle, then bits 1 to 39 follow it into the CRC
    assign crcEn = active ? (cnt < CntW'(HdrBits)) : (cmdIn == StartBit);
    assign lastBit = active && (cnt == CntW'(FrameBits - 1));
    assign frameOk = (sr[TxBitPos] == HostTxBit) && (sr[Crc7Bits-1:0] == crc) &&
                     (cmdIn == EndBit);

    sdCrc7 crcChk (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (!active),
        .enable (crcEn),
        .bitIn  (cmdIn),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        if (!rst_) begin
            active <= 1'b0;
            cnt <= '0;
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= 1'b0;
            if (!active) begin
                if (cmdIn == StartBit) begin
                    active <= 1'b1;
                    cnt <= CntW'(1);
                end
            end else if (lastBit) begin
                // Bad frames are dropped without a trace
                active <= 1'b0;
                cmd.valid <= frameOk;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        sr <= {sr[FrameBits-3:0], cmdIn};
        if (lastBit) begin
            cmd.index <= sr[IdxLsb +: 6];
            cmd.arg <= sr[ArgLsb +: 32];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdCrc7.sv ====
`default_nettype none

module sdCrc7 import sdBusPkg::*; (
    input  logic                clk,
    input  logic                rst_,
    input  logic                clear,
    input  logic                enable,
    input  logic                bitIn,
    output logic [Crc7Bits-1:0] crc
);

    // x^7 + x^3 + 1
    localparam logic [Crc7Bits-1:0] Poly = 7'h09;

    logic [Crc7Bits-1:0] base;
    logic                fb;

    // Clear together with enable starts a new frame on this bit
    assign base = clear ? '0 : crc;
    assign fb = bitIn ^ base[Crc7Bits-1];

    always_ff @(posedge clk) begin
        if (!rst_) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {base[Crc7Bits-2:0], 1'b0} ^ (fb ? Poly : '0);
        end else if (clear) begin
            crc <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdLinkIfs.sv ====
`default_nettype none

// Decoded command from the receiver, one-cycle valid per good frame
interface sdCmdIf import sdCmdPkg::*; ();
    logic     valid;
    cmdIndexT index;
    sdArgU    arg;

    modport rx (output valid, index, arg);
    modport ctl (input valid, index, arg);
endinterface

// Response request to the transmitter
interface sdRespIf import sdCmdPkg::*; ();
    logic        valid;
    cmdIndexT    index;
    logic [31:0] arg;
    // R3 sends all ones in place of the CRC
    logic        noCrc;
    logic        busy;

    modport ctl (output valid, index, arg, noCrc, input busy);
    modport tx (input valid, index, arg, noCrc, output busy);
endinterface

`default_nettype wire

// ==== hdl/sdReadDataSender.sv ====
`default_nettype none

module sdReadDataSender import sdBusPkg::*; #(
    parameter int BlockBytes = 512,
    // Counted from the response end bit, at least 2
    parameter int DataGap = 8
) (
    input  logic                clk,
    input  logic                rst_,
    input  logic                readStart,
    input  logic                readStop,
    output logic                readActive,
    output logic [DatLines-1:0] datOut,
    output logic                datOe
);

    localparam int DataBits = BlockBytes * 8;
    // pos 0 start, 1..DataBits data, then CRC, then end bit
    localparam int EndPos = DataBits + Crc16Bits + 1;
    localparam int PosW = $clog2(EndPos + 1);
    localparam int BlockGap = 2;
    localparam int GapW = $clog2(DataGap + 3);
    localparam logic [Crc16Bits-1:0] Poly = 16'h1021;

    logic [PosW-1:0]      pos;
    logic [PosW-1:0]      dataIdx;
    logic [GapW-1:0]      gapLeft;
    logic                 stopPend;
    logic                 stopNow;
    logic                 emit;
    logic [7:0]           byteVal;
    logic                 dataBit;
    logic [DatLines-1:0]  lineBits;
    logic [DatLines-1:0]  crcMsb;
    logic [Crc16Bits-1:0] crc [DatLines];

    assign stopNow = stopPend | readStop;
    // A stop seen before a start bit keeps that block from starting
    assign emit = readActive && !readStart && (gapLeft == '0) && !(pos == '0 && stopNow);

    // Byte n of a block holds n, MSB first
    assign dataIdx = pos - 1'b1;
    assign byteVal = 8'(dataIdx >> 3);
    assign dataBit = byteVal[~dataIdx[2:0]];
    assign lineBits = {DatLines{dataBit}};

    always_comb begin
        for (int i = 0; i < DatLines; i++) begin
            crcMsb[i] = crc[i][Crc16Bits-1];
        end
    end

    // ===================================================================
    // Block sequencing
    // ===================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            readActive <= 1'b0;
            stopPend <= 1'b0;
            gapLeft <= '0;
            pos <= '0;
            datOe <= 1'b0;
        end else begin
            datOe <= emit;
            if (readStart) begin
                readActive <= 1'b1;
                stopPend <= 1'b0;
                pos <= '0;
                gapLeft <= GapW'(DataGap - 2);
            end else if (readActive) begin
                stopPend <= stopNow;
                if (gapLeft != '0) begin
                    gapLeft <= gapLeft - 1'b1;
                end else if (!emit) begin
                    readActive <= 1'b0;
                end else if (pos == PosW'(EndPos)) begin
                    pos <= '0;
                    gapLeft <= GapW'(BlockGap);
                    readActive <= !stopNow;
                end else begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

    // ===================================================================
    // Line data and per-line CRC16
    // ===================================================================
    always_ff @(posedge clk) begin
        if (!emit) begin
            datOut <= '1;
        end else if (pos == '0) begin
            datOut <= {DatLines{StartBit}};
            for (int i = 0; i < DatLines; i++) begin
                crc[i] <= '0;
            end
        end else if (pos <= PosW'(DataBits)) begin
            datOut <= lineBits;
            for (int i = 0; i < DatLines; i++) begin
                crc[i] <= {crc[i][Crc16Bits-2:0], 1'b0} ^
                          ((lineBits[i] ^ crc[i][Crc16Bits-1]) ? Poly : '0);
            end
        end else if (pos < PosW'(EndPos)) begin
            datOut <= crcMsb;
            for (int i = 0; i < DatLines; i++) begin
                crc[i] <= crc[i] << 1;
            end
        end else begin
            datOut <= {DatLines{EndBit}};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdRespTransmitter.sv ====
`default_nettype none

module sdRespTransmitter import sdBusPkg::*; #(
    parameter int RespGap = 2
) (
    input  logic clk,
    input  logic rst_,
    sdRespIf.tx  resp,
    output logic cmdOut,
    output logic cmdOe
);

    localparam int CntW = $clog2(FrameBits + RespGap);

    typedef enum logic [1:0] {TxIdle, TxGap, TxSend} txStateT;

    txStateT             state;
    logic [CntW-1:0]     cnt;
    logic [HdrBits-1:0]  hdr;
    logic                noCrcQ;
    logic [Crc7Bits-1:0] crc;
    logic                gapDone;
    logic                crcEn;
    logic                nextBit;

    assign resp.busy = (state != TxIdle);
    assign gapDone = (state == TxGap) && (cnt == CntW'(RespGap - 1));
    // Header bits feed the CRC as they go out
    assign crcEn = gapDone || (state == TxSend && cnt < CntW'(HdrBits));

    sdCrc7 crcGen (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (state == TxIdle),
        .enable (crcEn),
        .bitIn  (hdr[HdrBits-1]),
        .crc    (crc)
    );

    // Bit cnt of the frame
    always_comb begin
        if (cnt < CntW'(HdrBits)) begin
            nextBit = hdr[HdrBits-1];
        end else if (cnt < CntW'(FrameBits - 1)) begin
            nextBit = noCrcQ | crc[3'(FrameBits - 2 - int'(cnt))];
        end else begin
            nextBit = EndBit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state <= TxIdle;
            cnt <= '0;
            cmdOe <= 1'b0;
            cmdOut <= 1'b1;
        end else begin
            case (state)
                TxIdle: begin
                    cmdOe <= 1'b0;
                    cmdOut <= 1'b1;
                    cnt <= '0;
                    if (resp.valid) begin
                        state <= TxGap;
                    end
                end
                TxGap: begin
                    if (gapDone) begin
                        state <= TxSend;
                        cmdOe <= 1'b1;
                        cmdOut <= nextBit;
                        cnt <= CntW'(1);
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TxSend: begin
                    cmdOut <= nextBit;
                    cnt <= cnt + 1'b1;
                    // End bit goes out, busy drops, cmdOe holds one more cycle
                    if (cnt == CntW'(FrameBits - 1)) begin
                        state <= TxIdle;
                    end
                end
                default: begin
                    state <= TxIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TxIdle && resp.valid) begin
            hdr <= {StartBit, CardTxBit, resp.index, resp.arg};
            noCrcQ <= resp.noCrc;
        end else if (crcEn) begin
            hdr <= hdr << 1;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
hdl/sdBusPkg.sv
hdl/sdCmdPkg.sv
hdl/sdLinkIfs.sv
hdl/sdCrc7.sv
hdl/sdCmdReceiver.sv
hdl/sdCardControl.sv
hdl/sdRespTransmitter.sv
hdl/sdReadDataSender.sv
hdl/sdCardTop.sv
tb/sdCardTb.sv

// ==== tb/sdHostModel.svh ====
`ifndef SD_HOST_MODEL_SVH
`define SD_HOST_MODEL_SVH

// ===================================================================
// Host side reference model, included inside the testbench module
// ===================================================================

logic [31:0] randState;
cardStateT   modelState;
logic        modelApp;

// LCG, upper half is returned since the low bits repeat quickly
function automatic logic [15:0] nextRand();
    randState = randState * 32'd1103515245 + 32'd12345;
    return randState[31:16];
endfunction

// CRC7 over the 40 header bits, x^7 + x^3 + 1
function automatic logic [6:0] crc7Of(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
        fb = bits[i] ^ crc[6];
        crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
endfunction

// One bit of CRC16, x^16 + x^12 + x^5 + 1
function automatic logic [15:0] crc16Step(input logic [15:0] crc, input logic bitIn);
    return {crc[14:0], 1'b0} ^ ((bitIn ^ crc[15]) ? 16'h1021 : 16'h0000);
endfunction

function automatic logic [47:0] makeFrame(input logic txBit, input logic [5:0] idx,
                                          input logic [31:0] arg, input logic noCrc);
    logic [39:0] hdr;
    hdr = {StartBit, txBit, idx, arg};
    return {hdr, noCrc ? 7'h7F : crc7Of(hdr), EndBit};
endfunction

// Bit k of a block, byte n holds n, MSB first
function automatic logic patternBit(input int k);
    logic [7:0] byteVal;
    byteVal = 8'(k / 8);
    return byteVal[7 - (k % 8)];
endfunction

// Expected response to a command, then the card state after it
task automatic predictCmd(input cmdIndexT idx, input logic [31:0] arg,
                          output logic hasResp, output logic [47:0] frame);
    logic [31:0] status;
    logic [31:0] rArg;
    cmdIndexT    rIdx;
    logic        noCrc;
    status = '0;
    status[StatusStateLsb +: 4] = modelState;
    status[StatusReadyBit] = 1'b1;
    status[StatusAppBit] = (idx == CmdAppCmd);
    hasResp = 1'b0;
    rIdx = idx;
    rArg = status;
    noCrc = 1'b0;
    if (modelApp && idx == AcmdOpCond) begin
        hasResp = 1'b1;
        rIdx = 6'h3F;
        rArg = OcrReady;
        noCrc = 1'b1;
        modelState = Ready;
    end else begin
        case (idx)
            CmdGoIdle: modelState = Idle;
            CmdSendRca: begin
                hasResp = 1'b1;
                rArg = {CardRca, status[15:0]};
                modelState = Stby;
            end
            CmdSelect: begin
                if (arg[31:16] == CardRca) begin
                    hasResp = 1'b1;
                    modelState = Tran;
                end
            end
            CmdIfCond: begin
                hasResp = 1'b1;
                rArg = {20'b0, arg[11:0]};
            end
            CmdStop: begin
                if (modelState == Data) begin
                    hasResp = 1'b1;
                    modelState = Tran;
                end
            end
            CmdReadMulti: begin
                if (modelState == Tran) begin
                    hasResp = 1'b1;
                    modelState = Data;
                end
            end
            CmdAppCmd: hasResp = 1'b1;
            default: hasResp = 1'b0;
        endcase
    end
    modelApp = (idx == CmdAppCmd);
    frame = makeFrame(CardTxBit, rIdx, rArg, noCrc);
endtask

// ===================================================================
// Command line frame tasks
// ===================================================================
task automatic sendFrame(input logic [47:0] frame);
    for (int i = FrameBits - 1; i >= 0; i--) begin
        @(negedge clk);
        cmdIn = frame[i];
    end
    @(negedge clk);
    cmdIn = 1'b1;
endtask

// Entered one cycle after the last command bit was sampled
task automatic readResponse(input string name, output logic [47:0] frame);
    int waited;
    waited = 0;
    while (cmdOe !== 1'b1) begin
        @(negedge clk);
        waited++;
        if (waited > 100) begin
            failRun({name, ": the card sent no response on the command line"});
        end
    end
    checkValue({name, " response latency"}, RespGap + 2, waited);
    frame[FrameBits-1] = cmdOut;
    for (int i = FrameBits - 2; i >= 0; i--) begin
        @(negedge clk);
        checkValue({name, " cmdOe during response"}, 1, cmdOe);
        frame[i] = cmdOut;
    end
    @(negedge clk);
    checkValue({name, " cmdOe after end bit"}, 0, cmdOe);
endtask

`endif

// ==== tb/sdCardTb.sv ====
`default_nettype none

module sdCardTb import sdBusPkg::*, sdCmdPkg::*; ();

    localparam logic [15:0] CardRca = 16'hAAAA;
    localparam int RespGap = 2;
    localparam int DataGap = 8;
    localparam int BlockBytes = 16;

    logic                clk;
    logic                rst_;
    logic                cmdIn;
    logic                cmdOut;
    logic                cmdOe;
    logic [DatLines-1:0] datOut;
    logic                datOe;

    `include "sdHostModel.svh"

    sdCardTop #(
        .CardRca    (CardRca),
        .RespGap    (RespGap),
        .DataGap    (DataGap),
        .BlockBytes (BlockBytes)
    ) DUT (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe),
        .datOut (datOut),
        .datOe  (datOe)
    );

    always #5 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("** Error: %s: expected %0h, actual %0h",
                              name, expected, actual));
        end
    endtask

    task automatic expectNoResponse(input string name);
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            if (cmdOe !== 1'b0) begin
                failRun({name, ": the card answered a command that needs no response"});
            end
        end
    endtask

    // Sends a command and checks the reply the model predicts
    task automatic runCmd(input string name, input cmdIndexT idx, input logic [31:0] arg);
        logic        hasResp;
        logic [47:0] expected;
        logic [47:0] actual;
        predictCmd(idx, arg, hasResp, expected);
        sendFrame(makeFrame(HostTxBit, idx, arg, 1'b0));
        if (hasResp) begin
            readResponse(name, actual);
            checkValue({name, " start and transmission bits"}, expected[47:46],
                       actual[47:46]);
            checkValue({name, " index"}, expected[45:40], actual[45:40]);
            checkValue({name, " argument"}, expected[39:8], actual[39:8]);
            checkValue({name, " crc"}, expected[7:1], actual[7:1]);
            checkValue({name, " end bit"}, expected[0], actual[0]);
        end else begin
            expectNoResponse(name);
        end
    endtask

    // Counts falling edges up to the first one that shows datOe high
    task automatic waitDatOe(input string name, input int limit, output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                failRun({name, ": no data block started on the data lines"});
            end
        end while (datOe !== 1'b1);
    endtask

    task automatic expectNoData(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (datOe !== 1'b0) begin
                failRun({name, ": a data block started after the stop command"});
            end
        end
    endtask

    // Called on the cycle that shows the start bit
    task automatic checkBlock(input string name);
        logic [15:0]         crc [DatLines];
        logic [DatLines-1:0] expLines;
        for (int l = 0; l < DatLines; l++) begin
            crc[l] = '0;
        end
        checkValue({name, " start bit"}, {1'b1, {DatLines{StartBit}}}, {datOe, datOut});
        for (int k = 0; k < BlockBytes * 8; k++) begin
            @(negedge clk);
            expLines = {DatLines{patternBit(k)}};
            for (int l = 0; l < DatLines; l++) begin
                crc[l] = crc16Step(crc[l], expLines[l]);
            end
            checkValue($sformatf("%s data bit %0d", name, k), {1'b1, expLines},
                       {datOe, datOut});
        end
        for (int j = 15; j >= 0; j--) begin
            @(negedge clk);
            for (int l = 0; l < DatLines; l++) begin
                expLines[l] = crc[l][j];
            end
            checkValue($sformatf("%s crc bit %0d", name, j), {1'b1, expLines},
                       {datOe, datOut});
        end
        @(negedge clk);
        checkValue({name, " end bit"}, {1'b1, {DatLines{EndBit}}}, {datOe, datOut});
    endtask

    function automatic cmdIndexT unknownIndex(input logic [15:0] r);
        cmdIndexT idx;
        idx = r[5:0];
        while (idx inside {CmdGoIdle, CmdSendRca, CmdSelect, CmdIfCond, CmdStop,
                           CmdReadMulti, CmdAppCmd, AcmdOpCond}) begin
            idx = idx + 1'b1;
        end
        return idx;
    endfunction

    initial begin
        int          waited;
        int          pos;
        logic [31:0] arg;
        logic [47:0] frame;
        logic [1:0]  kind;
        logic [1:0]  kindBase;
        clk = 1'b0;
        rst_ = 1'b0;
        cmdIn = 1'b1;
        randState = 32'd31;
        modelState = Idle;
        modelApp = 1'b0;
        repeat (10) @(negedge clk);
        rst_ = 1'b1;
        @(negedge clk);
        checkValue("reset cmdOe", 0, cmdOe);
        checkValue("reset datOe", 0, datOe);

        // ===================================================================
        // Init sequence and CMD8
        // ===================================================================
        runCmd("cmd0", CmdGoIdle, 32'h0);
        runCmd("cmd55 in idle", CmdAppCmd, 32'h0);
        runCmd("acmd41", AcmdOpCond, 32'h40FF_8000);
        runCmd("cmd3", CmdSendRca, 32'h0);
        runCmd("cmd7 select", CmdSelect, {CardRca, 16'h0});
        for (int i = 0; i < 4; i++) begin
            arg = {nextRand(), nextRand()};
            runCmd($sformatf("cmd8 #%0d", i), CmdIfCond, arg);
        end

        // ===================================================================
        // Corrupted frames and a wrong RCA
        // ===================================================================
        // Each corruption kind comes up twice from a random starting kind
        kindBase = 2'(nextRand());
        for (int i = 0; i < 8; i++) begin
            arg = {nextRand(), nextRand()};
            kind = kindBase + 2'(i);
            frame = makeFrame(HostTxBit, CmdIfCond, arg, 1'b0);
            if (kind == 2'd3) begin
                runCmd($sformatf("unknown index #%0d", i), unknownIndex(nextRand()), arg);
            end else begin
                if (kind == 2'd0) begin
                    // One of the seven CRC bits
                    pos = 1 + (nextRand() % 7);
                    frame[pos] = ~frame[pos];
                end else if (kind == 2'd1) begin
                    frame[0] = ~EndBit;
                end else begin
                    // CRC covers the wrong bit so only the transmission bit is bad
                    frame = makeFrame(~HostTxBit, CmdIfCond, arg, 1'b0);
                end
                sendFrame(frame);
                expectNoResponse($sformatf("bad frame #%0d kind %0d", i, kind));
            end
            runCmd($sformatf("cmd55 after bad frame #%0d", i), CmdAppCmd, 32'h0);
        end
        arg = {nextRand(), nextRand()};
        if (arg[31:16] == CardRca) begin
            arg[31:16] = ~CardRca;
        end
        runCmd("cmd7 wrong rca", CmdSelect, arg);
        runCmd("cmd55 after wrong rca", CmdAppCmd, 32'h0);

        // ===================================================================
        // Multi-block read and stop
        // ===================================================================
        runCmd("cmd18", CmdReadMulti, {nextRand(), nextRand()});
        // readResponse returns one cycle after the end bit
        waitDatOe("cmd18", 50, waited);
        checkValue("cmd18 data start delay", DataGap, waited + 1);
        checkBlock("block 1");
        // The count includes the start bit cycle
        waitDatOe("block gap 1", 20, waited);
        checkValue("block gap 1 idle cycles", 2, waited - 1);
        checkBlock("block 2");
        waitDatOe("block gap 2", 20, waited);
        checkValue("block gap 2 idle cycles", 2, waited - 1);
        fork
            checkBlock("block 3");
            runCmd("cmd12", CmdStop, 32'h0);
        join
        expectNoData("after cmd12", 200);
        runCmd("cmd55 after cmd12", CmdAppCmd, 32'h0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
